// ==== logic/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

    // architectural sizes
    localparam int xlen     = 32;
    localparam int num_regs = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      reg_idx_t;
    typedef logic [11:0]     csr_addr_t;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_imm    = 7'b0010011,
        op_op     = 7'b0110011,
        op_system = 7'b1110011
    } opcode_t;

    // funct3 codes of the integer ALU
    localparam logic [2:0] f3_add  = 3'b000;
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_sr   = 3'b101;
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    // word access and csr funct3
    localparam logic [2:0] f3_word  = 3'b010;
    localparam logic [2:0] f3_csrrw = 3'b001;
    localparam logic [2:0] f3_csrrs = 3'b010;

    // machine-mode csrs
    localparam csr_addr_t csr_mtvec  = 12'h305;
    localparam csr_addr_t csr_mepc   = 12'h341;
    localparam csr_addr_t csr_mcause = 12'h342;

    localparam word_t cause_ecall_m = 32'd11;
    localparam word_t reset_vector  = 32'h8000_0000;

    // fixed encodings
    localparam word_t nop_inst   = 32'h0000_0013;
    localparam word_t inst_ecall = 32'h0000_0073;
    localparam word_t inst_mret  = 32'h3020_0073;

endpackage

`default_nettype wire

// ==== logic/core_ctrl_pkg.sv ====
`default_nettype none

package core_ctrl_pkg;

    // alu operation
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_slt,
        alu_sltu,
        alu_pass_b
    } alu_op_t;

    // operand a source
    typedef enum logic [1:0] {
        src_a_rs1,
        src_a_pc,
        src_a_zero
    } src_a_t;

    // operand b source
    typedef enum logic [1:0] {
        src_b_rs2,
        src_b_imm,
        src_b_four
    } src_b_t;

    // next pc choice
    typedef enum logic [2:0] {
        pc_seq,
        pc_branch,
        pc_jal,
        pc_jalr,
        pc_trap,
        pc_mret
    } pc_sel_t;

    // register write-back source
    typedef enum logic [2:0] {
        wb_none,
        wb_alu,
        wb_mem,
        wb_csr,
        wb_pc4
    } wb_sel_t;

    // branch conditions, encoded as their funct3
    typedef enum logic [2:0] {
        cmp_eq  = 3'b000,
        cmp_ne  = 3'b001,
        cmp_lt  = 3'b100,
        cmp_ge  = 3'b101,
        cmp_ltu = 3'b110,
        cmp_geu = 3'b111
    } cmp_t;

    // csr access kind
    typedef enum logic [1:0] {
        csr_none,
        csr_write,
        csr_set
    } csr_op_t;

endpackage

`default_nettype wire

// ==== logic/rv_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_decoder
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;
(
    input  word_t     inst,
    output reg_idx_t  rs1,
    output reg_idx_t  rs2,
    output reg_idx_t  rd,
    output word_t     imm,
    output src_a_t    src_a,
    output src_b_t    src_b,
    output alu_op_t   alu_op,
    output cmp_t      cmp,
    output pc_sel_t   pc_sel,
    output wb_sel_t   wb_sel,
    output logic      reg_we,
    output logic      mem_we,
    output logic      mem_re,
    output csr_addr_t csr_addr,
    output csr_op_t   csr_op,
    output logic      ecall,
    output logic      mret
);

    word_t      fields;
    logic       legal;
    logic [2:0] funct3;
    logic       alt;

    // legality check on the raw word
    always_comb begin
        case (inst[6:0])
            op_lui, op_auipc, op_jal, op_imm, op_op: legal = 1'b1;
            op_jalr:  legal = (inst[14:12] == f3_add);
            // funct3 010 and 011 are not branches
            op_branch: legal = (inst[14:13] != 2'b01);
            op_load, op_store: legal = (inst[14:12] == f3_word);
            op_system: legal = (inst == inst_ecall) || (inst == inst_mret) ||
                               (inst[14:12] == f3_csrrw) || (inst[14:12] == f3_csrrs);
            default:  legal = 1'b0;
        endcase
    end

    // anything unsupported becomes addi x0,x0,0
    assign fields   = legal ? inst : nop_inst;
    assign funct3   = fields[14:12];
    // funct7 bit 5 picks sub and sra
    assign alt      = fields[30];

    assign rs1      = fields[19:15];
    assign rs2      = fields[24:20];
    assign rd       = fields[11:7];
    assign csr_addr = fields[31:20];

    always_comb begin
        // defaults are a nop that writes nothing
        imm    = '0;
        src_a  = src_a_rs1;
        src_b  = src_b_imm;
        alu_op = alu_add;
        cmp    = cmp_t'(funct3);
        pc_sel = pc_seq;
        wb_sel = wb_none;
        reg_we = 1'b0;
        mem_we = 1'b0;
        mem_re = 1'b0;
        csr_op = csr_none;
        ecall  = 1'b0;
        mret   = 1'b0;
        case (fields[6:0])
            op_lui: begin
                imm    = {fields[31:12], 12'b0};
                src_a  = src_a_zero;
                alu_op = alu_pass_b;
                wb_sel = wb_alu;
                reg_we = 1'b1;
            end
            op_auipc: begin
                imm    = {fields[31:12], 12'b0};
                src_a  = src_a_pc;
                wb_sel = wb_alu;
                reg_we = 1'b1;
            end
            op_jal: begin
                // link goes through the alu as pc + 4
                imm    = {{11{fields[31]}}, fields[31], fields[19:12], fields[20],
                          fields[30:21], 1'b0};
                src_a  = src_a_pc;
                src_b  = src_b_four;
                pc_sel = pc_jal;
                wb_sel = wb_alu;
                reg_we = 1'b1;
            end
            op_jalr: begin
                // alu forms the target, link from pc + 4
                imm    = {{20{fields[31]}}, fields[31:20]};
                pc_sel = pc_jalr;
                wb_sel = wb_pc4;
                reg_we = 1'b1;
            end
            op_branch: begin
                imm    = {{19{fields[31]}}, fields[31], fields[7], fields[30:25],
                          fields[11:8], 1'b0};
                src_b  = src_b_rs2;
                alu_op = alu_sub;
                pc_sel = pc_branch;
            end
            op_load: begin
                imm    = {{20{fields[31]}}, fields[31:20]};
                wb_sel = wb_mem;
                reg_we = 1'b1;
                mem_re = 1'b1;
            end
            op_store: begin
                imm    = {{20{fields[31]}}, fields[31:25], fields[11:7]};
                mem_we = 1'b1;
            end
            op_imm, op_op: begin
                imm    = {{20{fields[31]}}, fields[31:20]};
                src_b  = (fields[6:0] == op_op) ? src_b_rs2 : src_b_imm;
                wb_sel = wb_alu;
                reg_we = 1'b1;
                case (funct3)
                    // only register form has sub
                    f3_add:  alu_op = (alt && fields[6:0] == op_op) ? alu_sub : alu_add;
                    f3_sll:  alu_op = alu_sll;
                    f3_slt:  alu_op = alu_slt;
                    f3_sltu: alu_op = alu_sltu;
                    f3_xor:  alu_op = alu_xor;
                    f3_sr:   alu_op = alt ? alu_sra : alu_srl;
                    f3_or:   alu_op = alu_or;
                    default: alu_op = alu_and;
                endcase
            end
            op_system: begin
                if (fields == inst_ecall) begin
                    ecall  = 1'b1;
                    pc_sel = pc_trap;
                end else if (fields == inst_mret) begin
                    mret   = 1'b1;
                    pc_sel = pc_mret;
                end else begin
                    csr_op = (funct3 == f3_csrrw) ? csr_write : csr_set;
                    wb_sel = wb_csr;
                    reg_we = 1'b1;
                end
            end
            default: begin
                reg_we = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/rv_regfile.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_regfile
    import rv_isa_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     we,
    input  reg_idx_t waddr,
    input  word_t    wdata,
    input  reg_idx_t raddr_a,
    input  reg_idx_t raddr_b,
    output word_t    rdata_a,
    output word_t    rdata_b
);

    // x0 has no storage
    word_t regs [1:num_regs-1];

    // reset holds every register clear and blocks writes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // combinational reads, x0 reads zero
    assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

endmodule

`default_nettype wire

// ==== logic/rv_csr_file.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_csr_file
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  csr_addr_t addr,
    input  csr_op_t   op,
    input  word_t     wdata,
    output word_t     rdata,
    input  logic      ecall,
    input  logic      mret,
    input  word_t     pc,
    output word_t     mtvec,
    output word_t     mepc
);

    word_t mcause;
    word_t new_val;

    // read mux, unknown address reads zero
    always_comb begin
        case (addr)
            csr_mtvec:  rdata = mtvec;
            csr_mepc:   rdata = mepc;
            csr_mcause: rdata = mcause;
            default:    rdata = '0;
        endcase
    end

    // csrrw replaces, csrrs ors in
    assign new_val = (op == csr_write) ? wdata : (rdata | wdata);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtvec  <= '0;
            mepc   <= '0;
            mcause <= '0;
        end else if (ecall) begin
            // trap entry saves the ecall's own pc
            mepc   <= pc;
            mcause <= cause_ecall_m;
        end else if (op != csr_none && !mret) begin
            case (addr)
                csr_mtvec:  mtvec  <= new_val;
                csr_mepc:   mepc   <= new_val;
                csr_mcause: mcause <= new_val;
                default:    mcause <= mcause;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/rv_alu_exec.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_alu_exec
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;
(
    input  src_a_t  src_a,
    input  src_b_t  src_b,
    input  alu_op_t alu_op,
    input  cmp_t    cmp,
    input  pc_sel_t pc_sel,
    input  wb_sel_t wb_sel,
    input  logic    reg_we,
    input  logic    mem_we,
    input  logic    mem_re,
    input  word_t   rs1_data,
    input  word_t   rs2_data,
    input  word_t   imm,
    input  word_t   pc,
    input  word_t   csr_rdata,
    input  word_t   mtvec,
    input  word_t   mepc,
    input  word_t   dmem_rdata,
    output word_t   rd_data,
    output logic    rd_we,
    output word_t   csr_wdata,
    output word_t   next_pc,
    output word_t   dmem_addr,
    output word_t   dmem_wdata,
    output logic    dmem_we
);

    word_t op_a;
    word_t op_b;
    word_t alu_y;
    word_t pc4;
    logic  taken;

    assign pc4 = pc + 32'd4;

    // operand select
    always_comb begin
        case (src_a)
            src_a_pc:   op_a = pc;
            src_a_zero: op_a = '0;
            default:    op_a = rs1_data;
        endcase
        case (src_b)
            src_b_rs2:  op_b = rs2_data;
            src_b_four: op_b = 32'd4;
            default:    op_b = imm;
        endcase
    end

    // shift amount is the low five bits of b
    always_comb begin
        case (alu_op)
            alu_sub:    alu_y = op_a - op_b;
            alu_and:    alu_y = op_a & op_b;
            alu_or:     alu_y = op_a | op_b;
            alu_xor:    alu_y = op_a ^ op_b;
            alu_sll:    alu_y = op_a << op_b[4:0];
            alu_srl:    alu_y = op_a >> op_b[4:0];
            alu_sra:    alu_y = $signed(op_a) >>> op_b[4:0];
            alu_slt:    alu_y = {31'b0, $signed(op_a) < $signed(op_b)};
            alu_sltu:   alu_y = {31'b0, op_a < op_b};
            alu_pass_b: alu_y = op_b;
            default:    alu_y = op_a + op_b;
        endcase
    end

    // branch condition on the raw register values
    always_comb begin
        case (cmp)
            cmp_ne:  taken = (rs1_data != rs2_data);
            cmp_lt:  taken = ($signed(rs1_data) < $signed(rs2_data));
            cmp_ge:  taken = ($signed(rs1_data) >= $signed(rs2_data));
            cmp_ltu: taken = (rs1_data < rs2_data);
            cmp_geu: taken = (rs1_data >= rs2_data);
            default: taken = (rs1_data == rs2_data);
        endcase
    end

    always_comb begin
        case (pc_sel)
            pc_branch: next_pc = taken ? pc + imm : pc4;
            pc_jal:    next_pc = pc + imm;
            // jalr target has bit 0 cleared
            pc_jalr:   next_pc = {alu_y[31:1], 1'b0};
            pc_trap:   next_pc = mtvec;
            pc_mret:   next_pc = mepc;
            default:   next_pc = pc4;
        endcase
    end

    // write-back select
    always_comb begin
        case (wb_sel)
            wb_alu:  rd_data = alu_y;
            wb_mem:  rd_data = mem_re ? dmem_rdata : '0;
            wb_csr:  rd_data = csr_rdata;
            wb_pc4:  rd_data = pc4;
            default: rd_data = '0;
        endcase
    end

    assign rd_we      = reg_we && (wb_sel != wb_none);
    // csrrw and csrrs both take rs1
    assign csr_wdata  = rs1_data;

    // word store and load share the address
    assign dmem_addr  = alu_y;
    assign dmem_wdata = rs2_data;
    assign dmem_we    = mem_we;

endmodule

`default_nettype wire

// ==== logic/rv_pc_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_pc_unit
    import rv_isa_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  word_t next_pc,
    output word_t pc
);

    // one retire per edge, so load every cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= reset_vector;
        end else begin
            pc <= next_pc;
        end
    end

endmodule

`default_nettype wire

// ==== logic/rv_core_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_core_top
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    output word_t inst_addr,
    input  word_t inst,
    output word_t dmem_addr,
    output word_t dmem_wdata,
    output logic  dmem_we,
    input  word_t dmem_rdata
);

    // decoded fields
    reg_idx_t  rs1;
    reg_idx_t  rs2;
    reg_idx_t  rd;
    word_t     imm;
    src_a_t    src_a;
    src_b_t    src_b;
    alu_op_t   alu_op;
    cmp_t      cmp;
    pc_sel_t   pc_sel;
    wb_sel_t   wb_sel;
    logic      reg_we;
    logic      mem_we;
    logic      mem_re;
    csr_addr_t csr_addr;
    csr_op_t   csr_op;
    logic      ecall;
    logic      mret;

    // datapath
    word_t pc;
    word_t next_pc;
    word_t rs1_data;
    word_t rs2_data;
    word_t rd_data;
    logic  rd_we;
    word_t csr_wdata;
    word_t csr_rdata;
    word_t mtvec;
    word_t mepc;

    // fetch address is the pc itself
    assign inst_addr = pc;

    rv_pc_unit rv_pc_unit_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .next_pc (next_pc),
        .pc      (pc)
    );

    rv_decoder rv_decoder_i (
        .inst     (inst),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd),
        .imm      (imm),
        .src_a    (src_a),
        .src_b    (src_b),
        .alu_op   (alu_op),
        .cmp      (cmp),
        .pc_sel   (pc_sel),
        .wb_sel   (wb_sel),
        .reg_we   (reg_we),
        .mem_we   (mem_we),
        .mem_re   (mem_re),
        .csr_addr (csr_addr),
        .csr_op   (csr_op),
        .ecall    (ecall),
        .mret     (mret)
    );

    rv_regfile rv_regfile_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .we      (rd_we),
        .waddr   (rd),
        .wdata   (rd_data),
        .raddr_a (rs1),
        .raddr_b (rs2),
        .rdata_a (rs1_data),
        .rdata_b (rs2_data)
    );

    rv_csr_file rv_csr_file_i (
        .clk   (clk),
        .rst_n (rst_n),
        .addr  (csr_addr),
        .op    (csr_op),
        .wdata (csr_wdata),
        .rdata (csr_rdata),
        .ecall (ecall),
        .mret  (mret),
        .pc    (pc),
        .mtvec (mtvec),
        .mepc  (mepc)
    );

    rv_alu_exec rv_alu_exec_i (
        .src_a      (src_a),
        .src_b      (src_b),
        .alu_op     (alu_op),
        .cmp        (cmp),
        .pc_sel     (pc_sel),
        .wb_sel     (wb_sel),
        .reg_we     (reg_we),
        .mem_we     (mem_we),
        .mem_re     (mem_re),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .imm        (imm),
        .pc         (pc),
        .csr_rdata  (csr_rdata),
        .mtvec      (mtvec),
        .mepc       (mepc),
        .dmem_rdata (dmem_rdata),
        .rd_data    (rd_data),
        .rd_we      (rd_we),
        .csr_wdata  (csr_wdata),
        .next_pc    (next_pc),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we)
    );

endmodule

`default_nettype wire

// ==== sim/rv_tb_prog.svh ====
`ifndef RV_TB_PROG_SVH
`define RV_TB_PROG_SVH

// instruction encoders, one per rv32i format
function automatic word_t enc_r(input logic [6:0] f7, input reg_idx_t rs2,
                                input reg_idx_t rs1, input logic [2:0] f3,
                                input reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic word_t enc_i(input word_t imm, input reg_idx_t rs1,
                                input logic [2:0] f3, input reg_idx_t rd,
                                input logic [6:0] opc);
    return {imm[11:0], rs1, f3, rd, opc};
endfunction

function automatic word_t enc_s(input word_t imm, input reg_idx_t rs2, input reg_idx_t rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
endfunction

function automatic word_t enc_b(input word_t imm, input reg_idx_t rs2,
                                input reg_idx_t rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic word_t enc_u(input word_t imm, input reg_idx_t rd, input logic [6:0] opc);
    return {imm[31:12], rd, opc};
endfunction

function automatic word_t enc_j(input word_t imm, input reg_idx_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
endfunction

// register form result into x3, then stored
task automatic alu_r(input logic [6:0] f7, input logic [2:0] f3, input word_t exp,
                     input string name);
    emit(enc_r(f7, 2, 1, f3, 3), 1'b1);
    check_reg(3, exp, name);
endtask

// immediate form on x1, result into x3
task automatic alu_i(input word_t imm, input logic [2:0] f3, input word_t exp,
                     input string name);
    emit(enc_i(imm, 1, f3, 3, 7'b0010011), 1'b1);
    check_reg(3, exp, name);
endtask

// taken branch skips a poison store, not taken falls into a nop
task automatic branch(input logic [2:0] f3, input reg_idx_t rs1, input reg_idx_t rs2,
                      input bit taken);
    emit(enc_b(32'd8, rs2, rs1, f3), 1'b1);
    if (taken) begin
        emit(poison, 1'b0);
    end else begin
        emit(nop_inst, 1'b1);
    end
endtask

// a and b are the two operand words at dmem 0x0 and 0x4
task automatic build_program(input word_t a, input word_t b);
    int k;
    int h;
    // operand loads
    emit(enc_i(32'd0, 0, f3_word, 1, 7'b0000011), 1'b1);
    emit(enc_i(32'd4, 0, f3_word, 2, 7'b0000011), 1'b1);
    alu_r(7'h00, f3_add, a + b, "add");
    alu_r(7'h20, f3_add, a - b, "sub");
    alu_r(7'h00, f3_and, a & b, "and");
    alu_r(7'h00, f3_or, a | b, "or");
    alu_r(7'h00, f3_xor, a ^ b, "xor");
    alu_r(7'h00, f3_sll, a << b[4:0], "sll");
    alu_r(7'h00, f3_sr, a >> b[4:0], "srl");
    alu_r(7'h20, f3_sr, word_t'($signed(a) >>> b[4:0]), "sra");
    alu_r(7'h00, f3_slt, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0, "slt");
    alu_r(7'h00, f3_sltu, (a < b) ? 32'd1 : 32'd0, "sltu");
    alu_i(32'hffff_fffb, f3_add, a + 32'hffff_fffb, "addi");
    alu_i(32'h0000_07a5, f3_xor, a ^ 32'h0000_07a5, "xori");
    // imm bit 10 selects the arithmetic shift
    alu_i(32'h0000_0407, f3_sr, word_t'($signed(a) >>> 7), "srai");
    alu_i(32'hffff_ffff, f3_sltu, (a < 32'hffff_ffff) ? 32'd1 : 32'd0, "sltiu");
    emit(enc_u(32'h1234_5000, 3, 7'b0110111), 1'b1);
    check_reg(3, 32'h1234_5000, "lui");
    k = n;
    emit(enc_u(32'h0000_1000, 3, 7'b0010111), 1'b1);
    check_reg(3, pc_of(k) + 32'h0000_1000, "auipc");
    // branch operands 5 and -3
    emit(enc_i(32'd5, 0, f3_add, 10, 7'b0010011), 1'b1);
    emit(enc_i(32'hffff_fffd, 0, f3_add, 11, 7'b0010011), 1'b1);
    branch(3'b000, 10, 10, 1'b1);
    branch(3'b000, 10, 11, 1'b0);
    branch(3'b001, 10, 11, 1'b1);
    branch(3'b001, 10, 10, 1'b0);
    branch(3'b100, 11, 10, 1'b1);
    branch(3'b100, 10, 11, 1'b0);
    branch(3'b101, 10, 11, 1'b1);
    branch(3'b101, 11, 10, 1'b0);
    branch(3'b110, 10, 11, 1'b1);
    branch(3'b110, 11, 10, 1'b0);
    branch(3'b111, 11, 10, 1'b1);
    branch(3'b111, 10, 11, 1'b0);
    // jal over a poison store
    k = n;
    emit(enc_j(32'd8, 12), 1'b1);
    emit(poison, 1'b0);
    check_reg(12, pc_of(k) + 32'd4, "jal link");
    // jalr with bit 0 set in the target
    emit(enc_u(reset_vector, 13, 7'b0110111), 1'b1);
    k = n + 1;
    emit(enc_i(word_t'(4 * (k + 2) + 1), 13, f3_add, 13, 7'b0010011), 1'b1);
    emit(enc_i(32'd0, 13, 3'b000, 14, 7'b1100111), 1'b1);
    emit(poison, 1'b0);
    check_reg(14, pc_of(k) + 32'd4, "jalr link");
    // trap: lui, addi, csrrw, ecall, jal, then the handler
    h = n + 5;
    emit(enc_u(reset_vector, 5, 7'b0110111), 1'b1);
    emit(enc_i(word_t'(4 * h), 5, f3_add, 5, 7'b0010011), 1'b1);
    emit(enc_i(word_t'(csr_mtvec), 5, f3_csrrw, 0, 7'b1110011), 1'b1);
    k = n;
    emit(inst_ecall, 1'b1);
    // return point jumps over the handler, runs after mret
    emit(enc_j(32'd32, 0), 1'b0);
    emit(enc_i(word_t'(csr_mepc), 0, f3_csrrs, 6, 7'b1110011), 1'b1);
    emit(enc_i(word_t'(csr_mcause), 0, f3_csrrs, 7, 7'b1110011), 1'b1);
    check_reg(6, pc_of(k), "mepc");
    check_reg(7, 32'd11, "mcause");
    emit(enc_i(32'd4, 6, f3_add, 6, 7'b0010011), 1'b1);
    emit(enc_i(word_t'(csr_mepc), 6, f3_csrrw, 0, 7'b1110011), 1'b1);
    emit(inst_mret, 1'b1);
    trace.push_back(k + 1);
    emit(enc_i(word_t'(csr_mtvec), 0, f3_csrrs, 8, 7'b1110011), 1'b1);
    check_reg(8, pc_of(h), "mtvec");
    // x0 ignores writes
    emit(enc_u(32'habcd_e000, 0, 7'b0110111), 1'b1);
    check_reg(0, 32'd0, "x0");
    // final self-loop
    emit(enc_j(32'd0, 0), 1'b1);
endtask

`endif

// ==== sim/rv_core_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_core_tb
    import rv_isa_pkg::*;
;

    logic  clk = 1'b0;
    logic  rst_n = 1'b0;
    word_t inst_addr;
    word_t inst;
    word_t dmem_addr;
    word_t dmem_wdata;
    logic  dmem_we;
    word_t dmem_rdata;

    word_t rom [256];
    word_t dmem [128];

    // layout index and executed order of the program
    int    n = 0;
    int    trace [$];
    // entry 0 is covered by the reset check
    int    tidx = 1;
    bit    built = 1'b0;
    word_t st_addr = 32'h0000_0100;
    word_t exp_addr [$];
    word_t exp_data [$];
    string exp_name [$];

    // a store that must never run
    localparam word_t poison = 32'h1ff0_2e23;

    always #20 clk = ~clk;

    rv_core_top rv_core_top_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_addr  (inst_addr),
        .inst       (inst),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_rdata (dmem_rdata)
    );

    // combinational memories
    assign inst       = rom[inst_addr[9:2]];
    assign dmem_rdata = dmem[dmem_addr[8:2]];

    always @(posedge clk) begin
        if (rst_n && dmem_we) begin
            dmem[dmem_addr[8:2]] <= dmem_wdata;
        end
    end

    function automatic word_t pc_of(input int idx);
        return reset_vector + word_t'(idx * 4);
    endfunction

    task automatic emit(input word_t w, input bit run);
        rom[n] = w;
        if (run) begin
            trace.push_back(n);
        end
        n++;
    endtask

    task automatic check_reg(input reg_idx_t r, input word_t exp, input string name);
        emit(enc_s(st_addr, r, 0), 1'b1);
        exp_addr.push_back(st_addr);
        exp_data.push_back(exp);
        exp_name.push_back(name);
        st_addr += 32'd4;
    endtask

    task automatic stop_run();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic report_failure(input string reason);
        $display("%s", reason);
        stop_run();
    endtask

    task automatic report_mismatch(input string name, input word_t exp, input word_t act);
        $display("Mismatch in %s: expected %h, actual %h", name, exp, act);
        stop_run();
    endtask

    `include "rv_tb_prog.svh"

    initial begin
        void'($urandom(32'ha0f4));
        for (int i = 0; i < 256; i++) begin
            rom[i] = enc_i(word_t'(i), 0, f3_add, 0, 7'b0010011);
        end
        for (int i = 0; i < 128; i++) begin
            dmem[i] = $urandom();
        end
        // operand a negative and b positive so signed and unsigned ops differ
        dmem[0][31] = 1'b1;
        dmem[1][31] = 1'b0;
        // nonzero shift amount in b
        dmem[1][0]  = 1'b1;
        build_program(dmem[0], dmem[1]);
        built = 1'b1;
        repeat (10) @(negedge clk);
        rst_n <= 1'b1;
    end

    // sampled mid-cycle where everything has settled
    always @(negedge clk) begin
        if (!rst_n) begin
            assert (inst_addr == reset_vector)
                else report_mismatch("reset pc", reset_vector, inst_addr);
            assert (!dmem_we)
                else report_failure("store enable is high during reset");
        end else begin
            if (dmem_we) begin
                if (exp_addr.size() == 0) begin
                    report_failure("store seen with no store left to expect");
                end else begin
                    assert (dmem_addr == exp_addr[0])
                        else report_mismatch({exp_name[0], " address"}, exp_addr[0],
                                             dmem_addr);
                    assert (dmem_wdata == exp_data[0])
                        else report_mismatch({exp_name[0], " data"}, exp_data[0],
                                             dmem_wdata);
                    void'(exp_addr.pop_front());
                    void'(exp_data.pop_front());
                    void'(exp_name.pop_front());
                end
            end
            if (tidx < trace.size()) begin
                assert (inst_addr == pc_of(trace[tidx]))
                    else report_mismatch("pc trace", pc_of(trace[tidx]), inst_addr);
                tidx++;
            end else begin
                // parked on the self-loop
                assert (inst_addr == pc_of(trace[$]))
                    else report_mismatch("final loop pc", pc_of(trace[$]), inst_addr);
                if (exp_addr.size() == 0) begin
                    $display("Test passed");
                    $finish;
                end else begin
                    report_failure("program ended before all expected stores");
                end
            end
        end
    end

    // program length plus reset plus margin
    initial begin
        wait (built);
        repeat (trace.size() + 10 + 20) @(posedge clk);
        report_failure("timeout, the program never reached its final loop");
    end

endmodule

`default_nettype wire

// ==== rv_core_top.f ====
+incdir+sim
logic/rv_isa_pkg.sv
logic/core_ctrl_pkg.sv
logic/rv_decoder.sv
logic/rv_regfile.sv
logic/rv_csr_file.sv
logic/rv_alu_exec.sv
logic/rv_pc_unit.sv
logic/rv_core_top.sv
sim/rv_core_tb.sv

// ==== Makefile ====
TOP := rv_core_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f rv_core_top.f --top-module $(TOP)

sim:
	verilator --binary --timing -f rv_core_top.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Test passed"

clean:
	rm -rf obj_dir
